// File: filelist.f
+incdir+source
source/pet_pkg.sv
source/wb_interconnect.sv
source/register_file.sv
source/wb_ram.sv
source/cpu_timing.sv
source/pet_system.sv
testbench/tb_checker.sv
testbench/tb_pet_system.sv

// File: source/cpu_timing.sv
// CPU timing controller
// Turns the ready and reset request bits into the 6502 reset line and
// clock-enable strobe. Reset is stretched by RESET_HOLD cycles after the
// request drops; in run the enable pulses once every CPU_DIVIDER clocks

`timescale 1ns/1ps
`default_nettype none

`include "pet_defs.svh"

module cpu_timing #(
    parameter int RESET_HOLD  = `RESET_HOLD,
    parameter int CPU_DIVIDER = `CPU_DIVIDER
) (
    input  wire logic          wb_clock_i,
    input  wire logic          rst_n_i,
    input  wire logic          cpu_ready_i,
    input  wire logic          cpu_reset_request_i,
    output logic               cpu_reset_o,
    output logic               cpu_enable_o,
    output pet_pkg::cpu_state_t cpu_state_o
);
    import pet_pkg::*;

    // Widths sized so the terminal counts always fit
    localparam int HOLD_W = $clog2(RESET_HOLD + 2);
    localparam int DIV_W  = $clog2(CPU_DIVIDER + 1);

    cpu_state_t        state_q;
    cpu_state_t        state_d;
    logic [HOLD_W-1:0] hold_cnt_q;
    logic [DIV_W-1:0]  div_cnt_q;
    logic              hold_done;
    logic              reset_q;

    assign hold_done = hold_cnt_q == HOLD_W'(RESET_HOLD);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_d = state_q;
        case (state_q)
            CPU_RESET: begin
                // Leave once the request has stayed low long enough
                if (!cpu_reset_request_i && hold_done) begin
                    state_d = cpu_ready_i ? CPU_RUN : CPU_HALT;
                end
            end
            CPU_HALT: begin
                if (cpu_reset_request_i) begin
                    state_d = CPU_RESET;
                end else if (cpu_ready_i) begin
                    state_d = CPU_RUN;
                end
            end
            CPU_RUN: begin
                if (cpu_reset_request_i) begin
                    state_d = CPU_RESET;
                end else if (!cpu_ready_i) begin
                    state_d = CPU_HALT;
                end
            end
            default: state_d = CPU_RESET;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            state_q    <= CPU_RESET;
            reset_q    <= 1'b1;
            hold_cnt_q <= '0;
            div_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            reset_q <= state_d == CPU_RESET;

            // Hold count restarts while the request is high
            if (state_q != CPU_RESET || cpu_reset_request_i) begin
                hold_cnt_q <= '0;
            end else if (!hold_done) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end

            // Divider idles at zero outside run, so each entry restarts it
            if (state_q != CPU_RUN) begin
                div_cnt_q <= '0;
            end else if (div_cnt_q == DIV_W'(CPU_DIVIDER)) begin
                div_cnt_q <= DIV_W'(1);
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
        end
    end

    assign cpu_reset_o  = reset_q;
    assign cpu_enable_o = (state_q == CPU_RUN) && (div_cnt_q == DIV_W'(CPU_DIVIDER));
    assign cpu_state_o  = state_q;

    // Reset flop and FSM must never disagree into a clocked CPU in reset
    enable_in_reset_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        !(cpu_enable_o && cpu_reset_o));

    // Strobe is one cycle wide for any divider above one
    enable_single_a: assert property (@(posedge wb_clock_i)
        disable iff (!rst_n_i || CPU_DIVIDER < 2)
        cpu_enable_o |=> !cpu_enable_o);

endmodule

`default_nettype wire

// File: source/pet_defs.svh
// PET system control constants
// Bus widths, address map, register layout and CPU timing defaults
// shared by the package and the RTL

`ifndef PET_DEFS_SVH
`define PET_DEFS_SVH

// Bus widths
`define WB_ADDR_WIDTH 16
`define DATA_WIDTH 8

// RAM window, 2 KB at the bottom of the map
`define RAM_ADDR_WIDTH 11
`define RAM_BASE 16'h0000

// Register window, four registers
`define REG_BASE 16'hE800
`define REG_ADDR_WIDTH 2

// CPU control register and its bits
`define REG_CPU 0
`define REG_CPU_READY_BIT 0
`define REG_CPU_RESET_BIT 1

// Extra CPU reset cycles after the request drops
`define RESET_HOLD 4

// System clocks per CPU clock enable
`define CPU_DIVIDER 8

`endif

// File: source/pet_pkg.sv
// PET system control types
// Bus vectors, Wishbone request/response bundles and the CPU state encoding

`default_nettype none

package pet_pkg;

`include "pet_defs.svh"

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [`WB_ADDR_WIDTH-1:0]  wb_addr_t;
    typedef logic [`DATA_WIDTH-1:0]     wb_data_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // Master to target, Wishbone B4 pipelined
    typedef struct packed {
        wb_addr_t addr;
        wb_data_t data;
        logic     we;
        logic     cycle;
        logic     strobe;
    } wb_req_t;

    // Target to master
    typedef struct packed {
        wb_data_t data;
        logic     ack;
        logic     stall;
    } wb_rsp_t;

    // CPU timing FSM
    typedef enum logic [1:0] {
        CPU_RESET,
        CPU_HALT,
        CPU_RUN
    } cpu_state_t;

endpackage

`default_nettype wire

// File: source/pet_system.sv
// PET system control top level
// Wishbone master port into the interconnect, with the RAM window, the
// control register file and the CPU timing controller behind it

`timescale 1ns/1ps
`default_nettype none

module pet_system (
    input  wire logic             wb_clock_i,
    input  wire logic             rst_n_i,
    input  wire pet_pkg::wb_req_t wb_req_i,
    output pet_pkg::wb_rsp_t      wb_rsp_o,
    output logic                  cpu_reset_o,
    output logic                  cpu_enable_o,
    output pet_pkg::cpu_state_t   cpu_state_o
);
    import pet_pkg::*;

    // Target side of the bus
    wb_req_t reg_req;
    wb_rsp_t reg_rsp;
    wb_req_t ram_req;
    wb_rsp_t ram_rsp;

    // Register bits to CPU timing
    logic cpu_ready;
    logic cpu_reset_request;

    wb_interconnect wb_interconnect_i (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .m_req_i    (wb_req_i),
        .m_rsp_o    (wb_rsp_o),
        .reg_req_o  (reg_req),
        .reg_rsp_i  (reg_rsp),
        .ram_req_o  (ram_req),
        .ram_rsp_i  (ram_rsp)
    );

    register_file register_file_i (
        .wb_clock_i  (wb_clock_i),
        .rst_n_i     (rst_n_i),
        .req_i       (reg_req),
        .rsp_o       (reg_rsp),
        .cpu_ready_o (cpu_ready),
        .cpu_reset_o (cpu_reset_request)
    );

    wb_ram wb_ram_i (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .req_i      (ram_req),
        .rsp_o      (ram_rsp)
    );

    cpu_timing cpu_timing_i (
        .wb_clock_i          (wb_clock_i),
        .rst_n_i             (rst_n_i),
        .cpu_ready_i         (cpu_ready),
        .cpu_reset_request_i (cpu_reset_request),
        .cpu_reset_o         (cpu_reset_o),
        .cpu_enable_o        (cpu_enable_o),
        .cpu_state_o         (cpu_state_o)
    );

endmodule

`default_nettype wire

// File: source/register_file.sv
// Control register file
// Four byte registers on the Wishbone bus. The CPU register carries the
// ready and reset request bits that steer the CPU timing FSM.
// Read-before-write with a one-cycle ack

`timescale 1ns/1ps
`default_nettype none

`include "pet_defs.svh"

module register_file (
    input  wire logic             wb_clock_i,
    input  wire logic             rst_n_i,
    input  wire pet_pkg::wb_req_t req_i,
    output pet_pkg::wb_rsp_t      rsp_o,
    output logic                  cpu_ready_o,
    output logic                  cpu_reset_o
);
    import pet_pkg::*;

    localparam int REG_COUNT = 2 ** `REG_ADDR_WIDTH;

    wb_data_t  regs [REG_COUNT];
    wb_data_t  rd_data_q;
    reg_addr_t reg_addr;
    logic      sel;
    logic      ack_q;

    // Strobe is already gated by the interconnect decode
    assign sel      = req_i.cycle & req_i.strobe;
    assign reg_addr = req_i.addr[`REG_ADDR_WIDTH-1:0];

    // Register storage and ack
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            // CPU held in reset, not ready
            regs[`REG_CPU][`REG_CPU_READY_BIT] <= 1'b0;
            regs[`REG_CPU][`REG_CPU_RESET_BIT] <= 1'b1;
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel;
            if (sel && req_i.we) begin
                regs[reg_addr] <= req_i.data;
            end
        end
    end

    // Old contents, captured on the same edge as the write
    always_ff @(posedge wb_clock_i) begin
        if (sel) begin
            rd_data_q <= regs[reg_addr];
        end
    end

    assign rsp_o.data  = rd_data_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.stall = 1'b0;

    // Control levels to the CPU timing
    assign cpu_ready_o = regs[`REG_CPU][`REG_CPU_READY_BIT];
    assign cpu_reset_o = regs[`REG_CPU][`REG_CPU_RESET_BIT];

    // Every ack answers a strobe from the previous cycle
    ack_after_strobe_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        rsp_o.ack |-> $past(req_i.cycle && req_i.strobe));

endmodule

`default_nettype wire

// File: source/wb_interconnect.sv
// Wishbone interconnect
// Decodes the master address into the RAM or the register window, gates
// strobe to the selected target and merges the responses. Unmapped
// accesses get a zero ack one cycle later

`timescale 1ns/1ps
`default_nettype none

`include "pet_defs.svh"

module wb_interconnect (
    input  wire logic             wb_clock_i,
    input  wire logic             rst_n_i,
    input  wire pet_pkg::wb_req_t m_req_i,
    output pet_pkg::wb_rsp_t      m_rsp_o,
    output pet_pkg::wb_req_t      reg_req_o,
    input  wire pet_pkg::wb_rsp_t reg_rsp_i,
    output pet_pkg::wb_req_t      ram_req_o,
    input  wire pet_pkg::wb_rsp_t ram_rsp_i
);
    import pet_pkg::*;

    localparam wb_addr_t RAM_BASE_A = `RAM_BASE;
    localparam wb_addr_t REG_BASE_A = `REG_BASE;

    logic ram_sel;
    logic reg_sel;
    logic miss_q;

    // Window match on the bits above each window's index
    assign ram_sel = m_req_i.addr[`WB_ADDR_WIDTH-1:`RAM_ADDR_WIDTH]
                  == RAM_BASE_A[`WB_ADDR_WIDTH-1:`RAM_ADDR_WIDTH];
    assign reg_sel = m_req_i.addr[`WB_ADDR_WIDTH-1:`REG_ADDR_WIDTH]
                  == REG_BASE_A[`WB_ADDR_WIDTH-1:`REG_ADDR_WIDTH];

    // Fan out, strobe only reaches the selected target
    always_comb begin
        reg_req_o        = m_req_i;
        reg_req_o.strobe = m_req_i.strobe & reg_sel;
        ram_req_o        = m_req_i;
        ram_req_o.strobe = m_req_i.strobe & ram_sel;
    end

    // Nobody selected, answer ourselves next cycle
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= m_req_i.cycle & m_req_i.strobe & ~ram_sel & ~reg_sel;
        end
    end

    // OR merge, data qualified by each ack; a miss contributes zero data
    assign m_rsp_o.data  = (reg_rsp_i.ack ? reg_rsp_i.data : '0)
                         | (ram_rsp_i.ack ? ram_rsp_i.data : '0);
    assign m_rsp_o.ack   = reg_rsp_i.ack | ram_rsp_i.ack | miss_q;
    assign m_rsp_o.stall = reg_rsp_i.stall | ram_rsp_i.stall;

    // Windows are disjoint, so at most one responder per cycle
    ack_onehot_a: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
        $onehot0({reg_rsp_i.ack, ram_rsp_i.ack, miss_q}));

endmodule

`default_nettype wire

// File: source/wb_ram.sv
// Wishbone RAM window
// Byte-wide memory indexed by the low address bits.
// Registered read-before-write, ack one cycle after the strobe

`timescale 1ns/1ps
`default_nettype none

module wb_ram (
    input  wire logic             wb_clock_i,
    input  wire logic             rst_n_i,
    input  wire pet_pkg::wb_req_t req_i,
    output pet_pkg::wb_rsp_t      rsp_o
);
    import pet_pkg::*;

    localparam int DEPTH = 2 ** $bits(ram_addr_t);

    wb_data_t  mem [DEPTH];
    wb_data_t  rd_data_q;
    ram_addr_t ram_addr;
    logic      sel;
    logic      ack_q;

    assign sel      = req_i.cycle & req_i.strobe;
    assign ram_addr = req_i.addr[$bits(ram_addr_t)-1:0];

    // Array and read port
    always_ff @(posedge wb_clock_i) begin
        if (sel) begin
            rd_data_q <= mem[ram_addr];
            if (req_i.we) begin
                mem[ram_addr] <= req_i.data;
            end
        end
    end

    // Single-cycle ack
    always_ff @(posedge wb_clock_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= sel;
        end
    end

    assign rsp_o.data  = rd_data_q;
    assign rsp_o.ack   = ack_q;
    assign rsp_o.stall = 1'b0;

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
// Checker for the PET system control slice
// Models the RAM window, the register file and the CPU timing from the
// address map and timing rules, and compares the DUT on every clock edge

`timescale 1ns/1ps
`default_nettype none

`include "pet_defs.svh"

module tb_checker (
    input  wire logic                wb_clock_i,
    input  wire logic                rst_n_i,
    input  wire pet_pkg::wb_req_t    wb_req_i,
    input  wire pet_pkg::wb_rsp_t    wb_rsp_i,
    input  wire logic                cpu_reset_i,
    input  wire logic                cpu_enable_i,
    input  wire pet_pkg::cpu_state_t cpu_state_i,
    output int                       error_count_o,
    output int                       check_count_o
);
    import pet_pkg::*;

    localparam int RAM_DEPTH = 2 ** `RAM_ADDR_WIDTH;
    localparam int REG_COUNT = 2 ** `REG_ADDR_WIDTH;

    wb_data_t   ram_model [RAM_DEPTH];
    logic       ram_known [RAM_DEPTH];
    wb_data_t   reg_model [REG_COUNT];
    logic       pending;
    logic       exp_known;
    wb_data_t   exp_data;
    cpu_state_t m_state;
    logic       m_reset;
    logic       m_enable;
    int         low_cycles;
    int         run_cycles;

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
        check_count_o++;
        if (act !== exp) begin
            error_count_o++;
            $display("[FAIL] %0d ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // RAM contents survive reset so nothing is known at start
    initial begin
        error_count_o = 0;
        check_count_o = 0;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            ram_known[i] = 1'b0;
        end
    end

    always @(posedge wb_clock_i) begin : step
        logic       ready;
        logic       request;
        cpu_state_t next;
        wb_addr_t   addr;
        int         idx;
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                reg_model[i] = '0;
            end
            reg_model[`REG_CPU][`REG_CPU_RESET_BIT] = 1'b1;
            pending    = 1'b0;
            m_state    = CPU_RESET;
            m_reset    = 1'b1;
            m_enable   = 1'b0;
            low_cycles = 0;
            run_cycles = 0;
        end else begin
            compare("cpu_reset_o", m_reset, cpu_reset_i);
            compare("cpu_enable_o", m_enable, cpu_enable_i);
            compare("cpu_state_o", m_state, cpu_state_i);

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // CPU timing from register bits before this edge's write
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            ready   = reg_model[`REG_CPU][`REG_CPU_READY_BIT];
            request = reg_model[`REG_CPU][`REG_CPU_RESET_BIT];
            next    = m_state;
            if (request) begin
                next       = CPU_RESET;
                low_cycles = 0;
            end else if (m_state == CPU_RESET) begin
                // Released after RESET_HOLD+1 cycles of low request
                low_cycles++;
                if (low_cycles == `RESET_HOLD + 1) begin
                    next = ready ? CPU_RUN : CPU_HALT;
                end
            end else begin
                next = ready ? CPU_RUN : CPU_HALT;
            end
            // Cycles spent in run since entry
            run_cycles = (next == CPU_RUN && m_state == CPU_RUN) ? run_cycles + 1 : 0;
            m_enable   = next == CPU_RUN && run_cycles != 0
                      && run_cycles % `CPU_DIVIDER == 0;
            m_reset    = next == CPU_RESET;
            m_state    = next;

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Bus with ack exactly one edge after acceptance
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            compare("wb_rsp_o.stall", 1'b0, wb_rsp_i.stall);
            compare("wb_rsp_o.ack", pending, wb_rsp_i.ack);
            if (pending && wb_rsp_i.ack && exp_known) begin
                compare("wb_rsp_o.data", exp_data, wb_rsp_i.data);
            end

            pending = wb_req_i.cycle && wb_req_i.strobe && !wb_rsp_i.stall;
            if (pending) begin
                addr      = wb_req_i.addr;
                exp_known = 1'b1;
                // Unmapped reads as zero
                exp_data  = '0;
                if ((addr >> `RAM_ADDR_WIDTH) == (`RAM_BASE >> `RAM_ADDR_WIDTH)) begin
                    idx       = addr % RAM_DEPTH;
                    exp_known = ram_known[idx];
                    exp_data  = ram_model[idx];
                    if (wb_req_i.we) begin
                        ram_model[idx] = wb_req_i.data;
                        ram_known[idx] = 1'b1;
                    end
                end else if ((addr >> `REG_ADDR_WIDTH) == (`REG_BASE >> `REG_ADDR_WIDTH)) begin
                    idx      = addr % REG_COUNT;
                    exp_data = reg_model[idx];
                    if (wb_req_i.we) begin
                        reg_model[idx] = wb_req_i.data;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_pet_system.sv
// Testbench top for the PET system control slice
// Drives LFSR-based Wishbone traffic and CPU control sequences into the DUT.
// All comparing happens in the checker; this module paces the tests,
// bounds every wait and reports the result

`timescale 1ns/1ps
`default_nettype none

`include "pet_defs.svh"

module tb_pet_system;
    import pet_pkg::*;

    localparam int       LIMIT   = 64;
    localparam wb_addr_t CPU_REG = `REG_BASE + `REG_CPU;

    logic        wb_clock;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        cpu_reset;
    logic        cpu_enable;
    cpu_state_t  cpu_state;
    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          timeouts;
    int          mark;

    pet_system pet_system_i (
        .wb_clock_i   (wb_clock),
        .rst_n_i      (rst_n),
        .wb_req_i     (wb_req),
        .wb_rsp_o     (wb_rsp),
        .cpu_reset_o  (cpu_reset),
        .cpu_enable_o (cpu_enable),
        .cpu_state_o  (cpu_state)
    );

    tb_checker tb_checker_i (
        .wb_clock_i    (wb_clock),
        .rst_n_i       (rst_n),
        .wb_req_i      (wb_req),
        .wb_rsp_i      (wb_rsp),
        .cpu_reset_i   (cpu_reset),
        .cpu_enable_i  (cpu_enable),
        .cpu_state_i   (cpu_state),
        .error_count_o (errors),
        .check_count_o (checks)
    );

    // 100 ns clock
    initial begin
        wb_clock = 1'b0;
        forever #50 wb_clock = ~wb_clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function logic [15:0] take_bits(input int n);
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits   = {bits[14:0], lfsr_q[0]};
            lfsr_q = galois_step(lfsr_q);
        end
        return bits;
    endfunction

    // Half RAM, a quarter registers, a quarter anywhere (mostly unmapped)
    function wb_addr_t random_addr(input logic ram_only);
        logic [1:0] kind;
        kind = 2'(take_bits(2));
        if (ram_only || !kind[1]) begin
            return `RAM_BASE | take_bits(6);
        end
        if (!kind[0]) begin
            return `REG_BASE | take_bits(2);
        end
        return take_bits(16);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and wait tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0d ns: %s", $time, what);
    endtask

    // Pipelined request held until a rising edge without stall
    task automatic issue(input wb_addr_t addr, input wb_data_t data, input logic we);
        int n;
        @(negedge wb_clock);
        wb_req.addr   = addr;
        wb_req.data   = data;
        wb_req.we     = we;
        wb_req.cycle  = 1'b1;
        wb_req.strobe = 1'b1;
        n = 0;
        while (wb_rsp.stall !== 1'b0 && n < LIMIT) begin
            @(negedge wb_clock);
            n++;
        end
        if (wb_rsp.stall !== 1'b0) begin
            report_timeout("bus stall never dropped");
        end
    endtask

    // Strobe off while cycle stays up through the last ack
    task automatic close_cycle();
        int n;
        @(negedge wb_clock);
        wb_req.strobe = 1'b0;
        wb_req.we     = 1'b0;
        n = 0;
        while (wb_rsp.ack !== 1'b1 && n < LIMIT) begin
            @(negedge wb_clock);
            n++;
        end
        if (wb_rsp.ack !== 1'b1) begin
            report_timeout("no ack for the last request");
        end
        @(negedge wb_clock);
        wb_req.cycle = 1'b0;
    endtask

    task automatic burst(input logic ram_only, input int length);
        wb_addr_t addr;
        wb_data_t data;
        logic     we;
        for (int i = 0; i < length; i++) begin
            addr = random_addr(ram_only);
            data = wb_data_t'(take_bits(8));
            we   = 1'(take_bits(1));
            issue(addr, data, we);
        end
        close_cycle();
    endtask

    task automatic write_cpu_reg(input wb_data_t data);
        issue(CPU_REG, data, 1'b1);
        close_cycle();
    endtask

    task automatic wait_state(input cpu_state_t target);
        int n;
        n = 0;
        while (cpu_state !== target && n < LIMIT) begin
            @(negedge wb_clock);
            n++;
        end
        if (cpu_state !== target) begin
            report_timeout("CPU state did not reach the requested state");
        end
    endtask

    task automatic wait_enable_pulses(input int pulses);
        int seen;
        int n;
        seen = 0;
        n    = 0;
        while (seen < pulses && n < pulses * `CPU_DIVIDER + LIMIT) begin
            @(negedge wb_clock);
            if (cpu_enable === 1'b1) begin
                seen++;
            end
            n++;
        end
        if (seen < pulses) begin
            report_timeout("too few CPU enable pulses");
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %-16s finished, %0d new errors", name, errors + timeouts - mark);
        mark = errors + timeouts;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        lfsr_q   = 16'd69;
        rst_n    = 1'b0;
        wb_req   = '0;
        timeouts = 0;
        mark     = 0;
        repeat (8) @(negedge wb_clock);
        rst_n = 1'b1;

        // Idle bus, CPU held, then the CPU register
        repeat (2) @(negedge wb_clock);
        issue(CPU_REG, 8'h00, 1'b0);
        close_cycle();
        end_test("reset_state");

        // Fill a 64-byte slice back to back, then mixed bursts on it
        for (int i = 0; i < 64; i++) begin
            issue(wb_addr_t'(`RAM_BASE + i), wb_data_t'(take_bits(8)), 1'b1);
        end
        close_cycle();
        repeat (40) burst(1'b1, 1 + take_bits(2));
        end_test("ram_access");

        repeat (60) burst(1'b0, 1 + take_bits(2));
        end_test("reg_and_unmapped");

        // Reset request low then high again
        write_cpu_reg(8'h02);
        wait_state(CPU_RESET);
        write_cpu_reg(8'h00);
        wait_state(CPU_HALT);
        write_cpu_reg(8'h02);
        wait_state(CPU_RESET);
        write_cpu_reg(8'h00);
        wait_state(CPU_HALT);
        end_test("cpu_reset");

        // Run, count pulses, then halt and watch for stray pulses
        write_cpu_reg(8'h01);
        wait_state(CPU_RUN);
        wait_enable_pulses(4);
        write_cpu_reg(8'h00);
        wait_state(CPU_HALT);
        repeat (2 * `CPU_DIVIDER) @(negedge wb_clock);
        end_test("cpu_enable");

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
